// ==== hdl/fm_pkg.sv ====
/*
 * register map, parameter field codes and slot constants for the OPM
 * register block. slot = operator * 8 + channel, so address bits 4:3 pick
 * the operator and bits 2:0 the channel. slot count is fixed at 32
 */
package fm_pkg;

    // global registers below 0x20
    localparam logic [7:0] REG_TEST   = 8'h01;
    localparam logic [7:0] REG_KON    = 8'h08;  // key-on, goes to the store
    localparam logic [7:0] REG_NOISE  = 8'h0F;
    localparam logic [7:0] REG_CLKA1  = 8'h10;  // timer A bits 9:2
    localparam logic [7:0] REG_CLKA2  = 8'h11;  // timer A bits 1:0
    localparam logic [7:0] REG_CLKB   = 8'h12;
    localparam logic [7:0] REG_TIMER  = 8'h14;
    localparam logic [7:0] REG_LFRQ   = 8'h18;
    localparam logic [7:0] REG_PMDAMD = 8'h19;
    localparam logic [7:0] REG_CTW    = 8'h1B;

    localparam int SLOT_COUNT       = 32;
    localparam int SLOT_W           = 5;
    localparam int TIMER_B_PRESCALE = 16;  // cen pulses per timer B step
    localparam int BUSY_CEN         = 32;  // cen pulses of busy per data write

    // which stored register an update pulse writes
    // channel fields come first so the low two bits index the channel array
    typedef enum logic [3:0] {
        FLD_RLFBCON = 4'd0,   // 0x20  rl 7:6, fb 5:3, con 2:0
        FLD_KC      = 4'd1,   // 0x28  kc 6:0
        FLD_KF      = 4'd2,   // 0x30  kf 7:2
        FLD_PMSAMS  = 4'd3,   // 0x38  pms 6:4, ams 1:0
        FLD_DT1MUL  = 4'd4,   // 0x40  dt1 6:4, mul 3:0
        FLD_TL      = 4'd5,   // 0x60  tl 6:0
        FLD_KSAR    = 4'd6,   // 0x80  ks 7:6, ar 4:0
        FLD_AMSD1R  = 4'd7,   // 0xA0  amsen 7, d1r 4:0
        FLD_DT2D2R  = 4'd8,   // 0xC0  d2r 4:0
        FLD_D1LRR   = 4'd9,   // 0xE0  d1l 7:4, rr 3:0
        FLD_KEYON   = 4'd10   // 0x08  channel 2:0, operator mask 6:3
    } param_field_e;

endpackage

// ==== hdl/fm_mmr.sv ====
`timescale 1ns/1ps
/*
 * host side decoder. write is a one-clock strobe, a0 low latches the address
 * and a0 high writes data. there is no back-pressure, a write while busy is
 * still taken. parameter writes leave as an upd pulse one clock later.
 * status bits 6:2 read as zero
 */
module fm_mmr import fm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [7:0]        din,
    input  logic              write,
    input  logic              a0,
    output logic [7:0]        test_mode,
    output logic              ne,
    output logic [4:0]        nfrq,
    output logic [7:0]        lfo_freq,
    output logic              lfo_up,
    output logic [1:0]        lfo_w,
    output logic [6:0]        lfo_amd,
    output logic [6:0]        lfo_pmd,
    output logic              ct1,
    output logic              ct2,
    output logic              upd,
    output param_field_e      upd_field,
    output logic [SLOT_W-1:0] upd_slot,
    output logic [7:0]        upd_data,
    output logic [9:0]        value_a,
    output logic [7:0]        value_b,
    output logic [5:0]        timer_ctl,
    output logic              clr_a,
    output logic              clr_b,
    output logic [7:0]        status,
    input  logic              flag_a,
    input  logic              flag_b
);

    logic [7:0] addr;       // selected register
    logic       data_wr;
    logic       param_wr;
    logic       upd_pend;
    logic       busy;
    logic [$clog2(BUSY_CEN)-1:0] busy_cnt;

    // channel block 0x20..0x3F splits on bits 4:3, operators on bits 7:5
    function automatic param_field_e field_of(input logic [7:0] a);
        param_field_e f;
        if (a[7:5] == 3'd1) begin
            case (a[4:3])
                2'd0:    f = FLD_RLFBCON;
                2'd1:    f = FLD_KC;
                2'd2:    f = FLD_KF;
                default: f = FLD_PMSAMS;
            endcase
        end else begin
            case (a[7:5])
                3'd2:    f = FLD_DT1MUL;
                3'd3:    f = FLD_TL;
                3'd4:    f = FLD_KSAR;
                3'd5:    f = FLD_AMSD1R;
                3'd6:    f = FLD_DT2D2R;
                default: f = FLD_D1LRR;
            endcase
        end
        return f;
    endfunction

    assign data_wr  = write & a0;
    assign param_wr = data_wr & ((addr >= 8'h20) | (addr == REG_KON));
    assign status   = {busy, 5'd0, flag_b, flag_a};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr      <= '0;
            test_mode <= '0;
            ne        <= 1'b0;
            nfrq      <= '0;
            lfo_freq  <= '0;
            lfo_up    <= 1'b0;
            lfo_w     <= '0;
            lfo_amd   <= '0;
            lfo_pmd   <= '0;
            ct1       <= 1'b0;
            ct2       <= 1'b0;
            value_a   <= '0;
            value_b   <= '0;
            timer_ctl <= '0;
            clr_a     <= 1'b0;
            clr_b     <= 1'b0;
        end else begin
            lfo_up <= 1'b0;  // single clock pulses
            clr_a  <= 1'b0;
            clr_b  <= 1'b0;
            if (write && !a0)
                addr <= din;
            if (data_wr) begin
                case (addr)
                    REG_TEST:  test_mode <= din;
                    REG_NOISE: begin
                        ne   <= din[7];
                        nfrq <= din[4:0];
                    end
                    REG_CLKA1: value_a[9:2] <= din;
                    REG_CLKA2: value_a[1:0] <= din[1:0];
                    REG_CLKB:  value_b <= din;
                    REG_TIMER: begin
                        timer_ctl <= din[5:0];  // bits 5:4 mirror the clears
                        clr_a     <= din[4];
                        clr_b     <= din[5];
                    end
                    REG_LFRQ: begin
                        lfo_freq <= din;
                        lfo_up   <= 1'b1;
                    end
                    REG_PMDAMD: begin
                        if (din[7])
                            lfo_pmd <= din[6:0];
                        else
                            lfo_amd <= din[6:0];
                    end
                    REG_CTW: begin
                        ct2   <= din[7];
                        ct1   <= din[6];
                        lfo_w <= din[1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // field, slot and data settle on the write edge, upd follows a clock later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            upd_pend  <= 1'b0;
            upd       <= 1'b0;
            upd_field <= FLD_RLFBCON;
            upd_slot  <= '0;
            upd_data  <= '0;
        end else begin
            upd_pend <= param_wr;
            upd      <= upd_pend;
            if (param_wr) begin
                upd_data <= din;
                if (addr == REG_KON) begin
                    upd_field <= FLD_KEYON;
                    upd_slot  <= SLOT_W'(din[2:0]);  // channel only
                end else begin
                    upd_field <= field_of(addr);
                    upd_slot  <= addr[SLOT_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;       // restart on every data write
            busy_cnt <= '0;
        end else if (cen && busy) begin
            busy_cnt <= busy_cnt + 1'b1;
            if (int'(busy_cnt) == BUSY_CEN - 1)
                busy <= 1'b0;
        end
    end

endmodule

// ==== hdl/fm_param_store.sv ====
`timescale 1ns/1ps
/*
 * channel and operator parameter store with a 32-slot round robin readout.
 * each cen pulse moves to the next slot and registers its parameters.
 * registers are kept as raw bytes, the dt2 bits of 0xC0 have no output.
 * parameter bytes are undefined until written, key-on bits reset to zero
 */
module fm_param_store import fm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              upd,
    input  param_field_e      upd_field,
    input  logic [SLOT_W-1:0] upd_slot,
    input  logic [7:0]        upd_data,
    output logic [SLOT_W-1:0] slot,
    output logic              zero,
    output logic [1:0]        rl,
    output logic [2:0]        fb,
    output logic [2:0]        con,
    output logic [6:0]        kc,
    output logic [5:0]        kf,
    output logic [2:0]        pms,
    output logic [1:0]        ams,
    output logic [2:0]        dt1,
    output logic [3:0]        mul,
    output logic [6:0]        tl,
    output logic [1:0]        ks,
    output logic [4:0]        arate,
    output logic              amsen,
    output logic [4:0]        rate1,
    output logic [4:0]        rate2,
    output logic [3:0]        d1l,
    output logic [3:0]        rrate,
    output logic              keyon
);

    logic [7:0]            ch_mem [4][8];           // 4 registers x 8 channels
    logic [7:0]            op_mem [6][SLOT_COUNT];  // 6 registers x 32 slots
    logic [SLOT_COUNT-1:0] kon_mem;
    logic [SLOT_W-1:0]     next_slot;
    logic [2:0]            next_ch;
    logic [2:0]            op_sel;

    assign next_slot = slot + 1'b1;     // wraps 31 -> 0
    assign next_ch   = next_slot[2:0];
    assign op_sel    = 3'(upd_field - FLD_DT1MUL);

    always_ff @(posedge clk) begin
        if (upd) begin
            case (upd_field)
                FLD_RLFBCON, FLD_KC, FLD_KF, FLD_PMSAMS:
                    ch_mem[upd_field[1:0]][upd_slot[2:0]] <= upd_data;
                FLD_DT1MUL, FLD_TL, FLD_KSAR, FLD_AMSD1R, FLD_DT2D2R, FLD_D1LRR:
                    op_mem[op_sel][upd_slot] <= upd_data;
                default: ;  // key-on handled below
            endcase
        end
    end

    // key-on mask bit 3+n drives operator n of the channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kon_mem <= '0;
        end else if (upd && upd_field == FLD_KEYON) begin
            for (int op = 0; op < 4; op++)
                kon_mem[{2'(op), upd_slot[2:0]}] <= upd_data[3 + op];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot  <= '0;
            zero  <= 1'b0;
            rl    <= '0;
            fb    <= '0;
            con   <= '0;
            kc    <= '0;
            kf    <= '0;
            pms   <= '0;
            ams   <= '0;
            dt1   <= '0;
            mul   <= '0;
            tl    <= '0;
            ks    <= '0;
            arate <= '0;
            amsen <= 1'b0;
            rate1 <= '0;
            rate2 <= '0;
            d1l   <= '0;
            rrate <= '0;
            keyon <= 1'b0;
        end else if (cen) begin
            slot  <= next_slot;
            zero  <= (next_slot == '0);
            {rl, fb, con} <= ch_mem[0][next_ch];
            kc    <= ch_mem[1][next_ch][6:0];
            kf    <= ch_mem[2][next_ch][7:2];
            pms   <= ch_mem[3][next_ch][6:4];
            ams   <= ch_mem[3][next_ch][1:0];
            dt1   <= op_mem[0][next_slot][6:4];
            mul   <= op_mem[0][next_slot][3:0];
            tl    <= op_mem[1][next_slot][6:0];
            ks    <= op_mem[2][next_slot][7:6];
            arate <= op_mem[2][next_slot][4:0];
            amsen <= op_mem[3][next_slot][7];
            rate1 <= op_mem[3][next_slot][4:0];
            rate2 <= op_mem[4][next_slot][4:0];
            {d1l, rrate} <= op_mem[5][next_slot];
            keyon <= kon_mem[next_slot];
        end
    end

endmodule

// ==== hdl/fm_timers.sv ====
`timescale 1ns/1ps
/*
 * timers A and B. a timer counts only while its load bit is set, and sits
 * at its load value otherwise. flags set on overflow only when the irq
 * enable is on. a clear pulse wins over a set on the same edge
 */
module fm_timers import fm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [9:0] value_a,
    input  logic [7:0] value_b,
    input  logic [5:0] timer_ctl,
    input  logic       clr_a,
    input  logic       clr_b,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq
);

    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [$clog2(TIMER_B_PRESCALE)-1:0] pre_b;
    logic       load_a;
    logic       load_b;
    logic       irqen_a;
    logic       irqen_b;
    logic       ovf_a;
    logic       ovf_b;
    logic       step_b;

    assign load_a  = timer_ctl[0];
    assign load_b  = timer_ctl[1];
    assign irqen_a = timer_ctl[2];
    assign irqen_b = timer_ctl[3];

    assign step_b = cen & load_b & (int'(pre_b) == TIMER_B_PRESCALE - 1);
    assign ovf_a  = cen & load_a & (&cnt_a);
    assign ovf_b  = step_b & (&cnt_b);
    assign irq    = (flag_a & irqen_a) | (flag_b & irqen_b);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_a  <= '0;
            cnt_b  <= '0;
            pre_b  <= '0;
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (!load_a || ovf_a)
                cnt_a <= value_a;       // hold or reload
            else if (cen)
                cnt_a <= cnt_a + 1'b1;

            if (!load_b) begin
                pre_b <= '0;
                cnt_b <= value_b;
            end else if (cen) begin
                pre_b <= pre_b + 1'b1;
                if (ovf_b)
                    cnt_b <= value_b;
                else if (step_b)
                    cnt_b <= cnt_b + 1'b1;
            end

            if (clr_a)
                flag_a <= 1'b0;
            else if (ovf_a && irqen_a)
                flag_a <= 1'b1;
            if (clr_b)
                flag_b <= 1'b0;
            else if (ovf_b && irqen_b)
                flag_b <= 1'b1;
        end
    end

endmodule

// ==== hdl/fm_regs_top.sv ====
`timescale 1ns/1ps
/*
 * register block top. host writes go to the decoder, parameters come out
 * of the store one slot per cen pulse. irq and status come from the timers
 */
module fm_regs_top import fm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [7:0]        din,
    input  logic              write,
    input  logic              a0,
    output logic [7:0]        status,
    output logic              irq,
    output logic [7:0]        test_mode,
    output logic              ne,
    output logic [4:0]        nfrq,
    output logic [7:0]        lfo_freq,
    output logic              lfo_up,
    output logic [1:0]        lfo_w,
    output logic [6:0]        lfo_amd,
    output logic [6:0]        lfo_pmd,
    output logic              ct1,
    output logic              ct2,
    output logic [SLOT_W-1:0] slot,
    output logic              zero,
    output logic [1:0]        rl,
    output logic [2:0]        fb,
    output logic [2:0]        con,
    output logic [6:0]        kc,
    output logic [5:0]        kf,
    output logic [2:0]        pms,
    output logic [1:0]        ams,
    output logic [2:0]        dt1,
    output logic [3:0]        mul,
    output logic [6:0]        tl,
    output logic [1:0]        ks,
    output logic [4:0]        arate,
    output logic              amsen,
    output logic [4:0]        rate1,
    output logic [4:0]        rate2,
    output logic [3:0]        d1l,
    output logic [3:0]        rrate,
    output logic              keyon
);

    // decoder to store
    logic              upd;
    param_field_e      upd_field;
    logic [SLOT_W-1:0] upd_slot;
    logic [7:0]        upd_data;

    // decoder to timers and back
    logic [9:0]        value_a;
    logic [7:0]        value_b;
    logic [5:0]        timer_ctl;
    logic              clr_a;
    logic              clr_b;
    logic              flag_a;
    logic              flag_b;

    fm_mmr u_mmr (.*);

    fm_param_store u_store (.*);

    fm_timers u_timers (.*);

endmodule

// ==== sim/fm_regs_checker.sv ====
`timescale 1ns/1ps
/*
 * watches the register block pins and keeps its own register model.
 * compares on the falling edge, where host inputs and DUT outputs are
 * stable. per-slot outputs are compared only while round_chk is high,
 * since parameter bytes have no reset value
 */
module fm_regs_checker import fm_pkg::*; (
    input logic              clk, rst, cen, write, a0, round_chk,
    input logic [7:0]        din, status, test_mode, lfo_freq,
    input logic              irq, ne, lfo_up, ct1, ct2, zero, amsen, keyon,
    input logic [4:0]        nfrq, arate, rate1, rate2,
    input logic [1:0]        lfo_w, rl, ams, ks,
    input logic [6:0]        lfo_amd, lfo_pmd, kc, tl,
    input logic [SLOT_W-1:0] slot,
    input logic [2:0]        fb, con, pms, dt1,
    input logic [5:0]        kf,
    input logic [3:0]        mul, d1l, rrate
);

    int                    errors = 0;
    int                    checks = 0;
    logic [7:0]            addr_m;
    logic [39:0]           glob_m;      // test_mode ne nfrq lfo_freq lfo_w amd pmd ct1 ct2
    logic                  lfo_up_m;
    logic [7:0]            ch_m [4][8];
    logic [7:0]            op_m [6][SLOT_COUNT];
    logic [SLOT_COUNT-1:0] kon_m;
    logic [SLOT_W-1:0]     slot_m;      // expected round-robin slot
    logic [9:0]            va_m;
    logic [7:0]            vb_m;
    logic                  busy_m;
    int                    busy_n;
    logic [1:0]            armed;       // timer waiting for its first flag
    logic [1:0]            clr_m;
    int                    tcnt [2];
    int                    texp [2];

    function automatic logic [39:0] decode_global(input logic [39:0] g,
                                                  input logic [7:0] a,
                                                  input logic [7:0] d);
        logic [39:0] n;
        n = g;
        case (a)
            REG_TEST:  n[39:32] = d;
            REG_NOISE: n[31:26] = {d[7], d[4:0]};
            REG_LFRQ:  n[25:18] = d;
            REG_CTW: begin
                n[17:16] = d[1:0];
                n[1:0]   = {d[6], d[7]};
            end
            REG_PMDAMD: begin
                if (d[7])
                    n[8:2] = d[6:0];
                else
                    n[15:9] = d[6:0];
            end
            default: ;
        endcase
        return n;
    endfunction

    // per-slot outputs of slot s in port order
    function automatic logic [66:0] expect_slot(input logic [SLOT_W-1:0] s);
        return {ch_m[0][s[2:0]], ch_m[1][s[2:0]][6:0], ch_m[2][s[2:0]][7:2],
                ch_m[3][s[2:0]][6:4], ch_m[3][s[2:0]][1:0],
                op_m[0][s][6:0], op_m[1][s][6:0], op_m[2][s][7:6], op_m[2][s][4:0],
                op_m[3][s][7], op_m[3][s][4:0], op_m[4][s][4:0], op_m[5][s], kon_m[s]};
    endfunction

    function automatic int cens_to_overflow(input int t, input int v);
        if (t == 0)
            return 1024 - v;
        return (256 - v) * TIMER_B_PRESCALE;   // prescaler starts from zero on load
    endfunction

    task automatic compare_value(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic apply_write(input logic [7:0] a, input logic [7:0] d);
        glob_m   = decode_global(glob_m, a, d);
        lfo_up_m = (a == REG_LFRQ);
        case (a)
            REG_CLKA1: va_m[9:2] = d;
            REG_CLKA2: va_m[1:0] = d[1:0];
            REG_CLKB:  vb_m = d;
            REG_KON: begin
                for (int op = 0; op < 4; op++)
                    kon_m[op * 8 + int'(d[2:0])] = d[3 + op];
            end
            REG_TIMER: begin
                clr_m = d[5:4];
                for (int t = 0; t < 2; t++) begin
                    armed[t] = d[t] & d[2 + t];
                    tcnt[t]  = 0;
                    texp[t]  = cens_to_overflow(t, (t == 0) ? int'(va_m) : int'(vb_m));
                end
            end
            default: begin
                if (a >= 8'h40)
                    op_m[a[7:5] - 3'd2][a[4:0]] = d;
                else if (a >= 8'h20)
                    ch_m[a[4:3]][a[2:0]] = d;
            end
        endcase
    endtask

    always @(negedge clk) begin
        logic [1:0] clr_now;
        if (rst) begin
            addr_m   = '0;
            glob_m   = '0;
            lfo_up_m = 1'b0;
            kon_m    = '0;
            slot_m   = '0;
            va_m     = '0;
            vb_m     = '0;
            busy_m   = 1'b0;
            busy_n   = 0;
            armed    = '0;
            clr_m    = '0;
        end else begin
            clr_now  = clr_m;
            clr_m    = '0;
            lfo_up_m = 1'b0;
            if (cen)
                slot_m = slot_m + 1'b1;  // wraps 31 -> 0
            // count cen before a new timer write can rearm
            for (int t = 0; t < 2; t++) begin
                if (armed[t]) begin
                    if (cen)
                        tcnt[t]++;
                    if (status[t]) begin
                        compare_value($sformatf("timer %0d cens", t), texp[t], tcnt[t]);
                        compare_value("irq", 1, irq);
                        armed[t] = 1'b0;
                    end else if (tcnt[t] > texp[t] + 4) begin
                        errors++;
                        $display("timer %0d flag did not set within %0d cen pulses",
                                 t, texp[t] + 4);
                        armed[t] = 1'b0;
                    end
                end
            end
            if (write && a0) begin
                busy_m = 1'b1;
                busy_n = 0;
                apply_write(addr_m, din);
            end else if (cen && busy_m) begin
                busy_n++;
                if (busy_n == BUSY_CEN)
                    busy_m = 1'b0;
            end
            if (write && !a0)
                addr_m = din;

            compare_value("globals", glob_m, {test_mode, ne, nfrq, lfo_freq, lfo_w,
                                              lfo_amd, lfo_pmd, ct1, ct2});
            compare_value("lfo_up", lfo_up_m, lfo_up);
            compare_value("busy", busy_m, status[7]);
            compare_value("slot", slot_m, slot);
            for (int t = 0; t < 2; t++) begin
                if (clr_now[t])
                    compare_value($sformatf("timer %0d flag clear", t), 0, status[t]);
            end
            if (clr_now == 2'b11)
                compare_value("irq clear", 0, irq);
            if (round_chk) begin
                compare_value("store zero", slot_m == '0, zero);
                compare_value($sformatf("store slot %0d", slot_m), expect_slot(slot_m),
                              {rl, fb, con, kc, kf, pms, ams, dt1, mul, tl, ks, arate,
                               amsen, rate1, rate2, d1l, rrate, keyon});
            end
        end
    end

endmodule

// ==== sim/tb_fm_regs.sv ====
`timescale 1ns/1ps
/*
 * testbench for the OPM register block. inputs change on the falling edge
 * and cen is high one clock in four. all comparing is done in the checker.
 * parameter registers are written before any slot round is compared
 */
module tb_fm_regs import fm_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              cen = 1'b0;
    logic [7:0]        din;
    logic              write;
    logic              a0;
    logic              round_chk;       // enables per-slot compare in the checker
    logic [7:0]        status, test_mode, lfo_freq;
    logic              irq, ne, lfo_up, ct1, ct2, zero, amsen, keyon;
    logic [4:0]        nfrq, arate, rate1, rate2;
    logic [1:0]        lfo_w, rl, ams, ks;
    logic [6:0]        lfo_amd, lfo_pmd, kc, tl;
    logic [SLOT_W-1:0] slot;
    logic [2:0]        fb, con, pms, dt1;
    logic [5:0]        kf;
    logic [3:0]        mul, d1l, rrate;
    logic [1:0]        cen_div = 2'd0;
    logic [31:0]       rng = 32'd20741;
    int                timeouts = 0;

    fm_regs_top u_fm_regs_top (.*);

    fm_regs_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        cen_div <= cen_div + 2'd1;
        cen     <= (cen_div == 2'd3);
    end

    // xorshift32 with the low byte as data
    function automatic logic [7:0] rand_byte();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng[7:0];
    endfunction

    task automatic bus_cycle(input logic sel, input logic [7:0] val);
        @(negedge clk);
        a0    <= sel;
        din   <= val;
        write <= 1'b1;
        @(negedge clk);
        write <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] val);
        bus_cycle(1'b0, addr);
        bus_cycle(1'b1, val);
    endtask

    task automatic wait_status(input logic [7:0] mask, input logic [7:0] want,
                               input int limit, input string what);
        int n;
        n = 0;
        while ((status & mask) != want && n < limit) begin
            @(negedge clk);
            n++;
        end
        if ((status & mask) != want) begin
            timeouts++;
            $display("timeout waiting for %s after %0d clocks", what, limit);
        end
    endtask

    // once busy is low every slot has been reloaded from the store
    task automatic check_round();
        wait_status(8'h80, 8'h00, 4 * BUSY_CEN + 8, "busy low");
        round_chk <= 1'b1;
        repeat (4 * SLOT_COUNT + 4) @(negedge clk);
        round_chk <= 1'b0;
    endtask

    initial begin
        rst       = 1'b1;
        din       = '0;
        write     = 1'b0;
        a0        = 1'b0;
        round_chk = 1'b0;
        repeat (8) @(negedge clk);
        rst <= 1'b0;

        write_reg(REG_TEST, rand_byte());
        write_reg(REG_NOISE, rand_byte());
        write_reg(REG_LFRQ, rand_byte());
        write_reg(REG_PMDAMD, rand_byte() | 8'h80);  // pmd side
        write_reg(REG_PMDAMD, rand_byte() & 8'h7F);  // amd side
        write_reg(REG_CTW, rand_byte());
        write_reg(REG_KON, rand_byte());
        write_reg(REG_CLKA1, rand_byte());
        write_reg(REG_CLKA2, rand_byte());
        write_reg(REG_CLKB, rand_byte());

        // address-only write leaves busy low
        wait_status(8'h80, 8'h00, 4 * BUSY_CEN + 8, "busy low");
        bus_cycle(1'b0, REG_TEST);
        repeat (16) @(negedge clk);

        for (int a = 8'h20; a < 256; a++)
            write_reg(8'(a), rand_byte());
        check_round();

        repeat (3) begin
            write_reg(REG_KON, rand_byte() & 8'h7F);
            check_round();
        end

        write_reg(REG_TIMER, 8'h30);               // timers off and flags cleared
        write_reg(REG_CLKA1, 8'hFE);
        write_reg(REG_CLKA2, rand_byte());
        write_reg(REG_CLKB, 8'hFC | rand_byte());
        write_reg(REG_TIMER, 8'h0F);               // load and irq enable on both
        wait_status(8'h03, 8'h03, 4 * TIMER_B_PRESCALE * 4 + 64, "timer flags");
        write_reg(REG_TIMER, 8'h3C);               // clear flags with irq enables kept
        repeat (8) @(negedge clk);

        $display("checks %0d errors %0d timeouts %0d",
                 u_checker.checks, u_checker.errors, timeouts);
        if (u_checker.errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/fm_pkg.sv
hdl/fm_mmr.sv
hdl/fm_param_store.sv
hdl/fm_timers.sv
hdl/fm_regs_top.sv
sim/fm_regs_checker.sv
sim/tb_fm_regs.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -j 0 -f vlog.f --top-module tb_fm_regs -Mdir obj_dir
	./obj_dir/Vtb_fm_regs | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
